// ==== Bender.yml ====
package:
  name: dp_exec_unit

sources:
  - hdl/cpuPkg.sv
  - hdl/registerFile.sv
  - hdl/operandShifter.sv
  - hdl/aluCore.sv
  - hdl/statusFlags.sv
  - hdl/wbSequencer.sv
  - hdl/dpTop.sv
  - target: simulation
    files:
      - bench/dpChecker.sv
      - bench/dpTopTb.sv

// ==== bench/dpChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

module dpChecker (
    input  logic                          Clk,
    input  logic                          cyc,
    input  logic                          stb,
    input  logic                          we,
    input  logic [4:0]                    adr,
    input  logic                          ack,
    input  logic [cpuPkg::dataWidth-1:0]  datOut,
    output int                            readCount,
    output int                            errorCount
);
    import cpuPkg::*;

    string                expName;
    logic [dataWidth-1:0] expValue;
    int                   ackCount;
    int                   waitCycles;
    int                   expWait;
    logic                 lastAck;

    task automatic loadExpected(input string name, input logic [dataWidth-1:0] value);
        expName  = name;
        expValue = value;
    endtask

    task automatic printCounts();
        $display("%0d tests done, %0d reads checked, %0d mismatches",
                 ackCount, readCount, errorCount);
    endtask

    initial begin
        readCount  = 0;
        errorCount = 0;
        ackCount   = 0;
        lastAck    = 1'b0;
    end

    // Rising edges seen with the request up, the sampling edge counts as one
    always @(posedge Clk) begin
        if (cyc && stb)
            waitCycles <= waitCycles + 1;
        else
            waitCycles <= 0;
    end

    // Ack lasts one cycle so each transfer shows up here once
    always @(negedge Clk) begin
        if (ack && lastAck) begin
            errorCount++;
            $display("ERROR: ack stayed high for more than one cycle");
        end
        lastAck = ack;
        if (cyc && stb && ack) begin
            ackCount++;
            expWait = (we && adr == addrInstr) ? 3 : 1;  // Three cycles per instruction
            if (waitCycles != expWait) begin
                errorCount++;
                $display("MISMATCH %s ack latency expected %0d actual %0d",
                         expName, expWait, waitCycles);
            end
            if (we) begin
                $display("done     %s", expName);
            end else begin
                readCount++;
                if (datOut !== expValue) begin
                    errorCount++;
                    $display("MISMATCH %s expected %h actual %h", expName, expValue, datOut);
                end else begin
                    $display("ok       %s = %h", expName, datOut);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/dpTopTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dpTopTb;
    import cpuPkg::*;

    localparam int clkPeriod = 8;
    localparam int kindRegWr = 0, kindFlagWr = 1, kindInstr = 2, kindRegRd = 3, kindFlagRd = 4;
    localparam logic [3:0] opAnd = 4'h0, opEor = 4'h1, opSub = 4'h2, opRsb = 4'h3;
    localparam logic [3:0] opAdd = 4'h4, opAdc = 4'h5, opSbc = 4'h6, opRsc = 4'h7;
    localparam logic [3:0] opTst = 4'h8, opTeq = 4'h9, opCmp = 4'ha, opCmn = 4'hb;
    localparam logic [3:0] opOrr = 4'hc, opMov = 4'hd, opBic = 4'he, opMvn = 4'hf;

    logic Clk, reset, cyc, stb, we, ack;
    logic [4:0]           adr;
    logic [dataWidth-1:0] datIn, datOut;
    int                   readCount, errorCount;
    int                   numTests = 0;
    int                   expectedReads = 0;

    string                names[$];
    int                   kinds[$];
    logic [4:0]           addrs[$];
    logic [dataWidth-1:0] datas[$];
    logic [dataWidth-1:0] exps[$];

    dpTop uut (
        .Clk(Clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datIn(datIn), .datOut(datOut), .ack(ack)
    );

    dpChecker busCheck (
        .Clk(Clk), .cyc(cyc), .stb(stb), .we(we), .adr(adr), .ack(ack), .datOut(datOut),
        .readCount(readCount), .errorCount(errorCount)
    );

    function automatic logic [31:0] immWord(input logic [3:0] cond, input logic [3:0] op,
            input int s, input int rn, input int rd, input int rot, input int imm8);
        return {cond, 2'b00, 1'b1, op, s[0], rn[3:0], rd[3:0], rot[3:0], imm8[7:0]};
    endfunction

    function automatic logic [31:0] regWord(input logic [3:0] cond, input logic [3:0] op,
            input int s, input int rn, input int rd, input int amt, input logic [1:0] typ,
            input int rm);
        return {cond, 2'b00, 1'b0, op, s[0], rn[3:0], rd[3:0], amt[4:0], typ, 1'b0, rm[3:0]};
    endfunction

    task automatic addEntry(input string name, input int kind, input logic [4:0] addr,
            input logic [31:0] data, input logic [31:0] expected);
        names.push_back(name);
        kinds.push_back(kind);
        addrs.push_back(addr);
        datas.push_back(data);
        exps.push_back(expected);
        if (kind >= kindRegRd) expectedReads++;
    endtask

    // Instruction followed by reads of Rd and the flags
    task automatic addExec(input string name, input logic [31:0] word, input int rd,
            input logic [31:0] expRd, input logic [3:0] expFlags);
        addEntry(name, kindInstr, addrInstr, word, 32'h0);
        addEntry({name, " rd"}, kindRegRd, 5'(rd), 32'h0, expRd);
        addEntry({name, " nzcv"}, kindFlagRd, addrFlags, 32'h0, {28'h0, expFlags});
    endtask

    task automatic buildTable();
        integer      seed;
        logic [31:0] value;
        seed = 32'h3c966421;
        for (int r = 0; r < 15; r++) begin
            value = $random(seed);
            addEntry($sformatf("r%0d write", r), kindRegWr, 5'(r), value, 32'h0);
            addEntry($sformatf("r%0d read", r), kindRegRd, 5'(r), 32'h0, value);
        end
        addEntry("r15 write", kindRegWr, 5'd15, 32'hffffffff, 32'h0);
        addEntry("r15 read", kindRegRd, 5'd15, 32'h0, 32'h0);
        addEntry("r1 load", kindRegWr, 5'd1, 32'h7fffffff, 32'h0);
        addEntry("r2 load", kindRegWr, 5'd2, 32'h00000005, 32'h0);
        addEntry("r3 load", kindRegWr, 5'd3, 32'h80000000, 32'h0);
        addEntry("r4 load", kindRegWr, 5'd4, 32'hf0f0f0f0, 32'h0);
        addEntry("r5 load", kindRegWr, 5'd5, 32'h12345678, 32'h0);
        addExec("ADDS ovf", immWord(condAl, opAdd, 1, 1, 6, 1, 8'h01), 6, 32'hbfffffff, 4'h9);
        addExec("ADDS zero", immWord(condAl, opAdd, 1, 3, 7, 4, 8'h80), 7, 32'h0, 4'h7);
        addExec("SUBS borrow", immWord(condAl, opSub, 1, 2, 8, 0, 8'h06), 8, 32'hffffffff, 4'ha);
        addExec("SUBS ovf", immWord(condAl, opSub, 1, 3, 9, 0, 8'h01), 9, 32'h7fffffff, 4'h1);
        addExec("RSBS rot", immWord(condAl, opRsb, 1, 2, 10, 15, 8'h03), 10, 32'h7, 4'h0);
        addEntry("C set", kindFlagWr, addrFlags, 32'h2, 32'h0);
        addExec("ADCS c1", immWord(condAl, opAdc, 1, 2, 11, 0, 8'h10), 11, 32'h16, 4'h0);
        addExec("ADCS c0", immWord(condAl, opAdc, 1, 2, 11, 0, 8'h10), 11, 32'h15, 4'h0);
        addEntry("C set", kindFlagWr, addrFlags, 32'h2, 32'h0);
        addExec("SBCS c1", immWord(condAl, opSbc, 1, 5, 12, 0, 8'h78), 12, 32'h123455ff, 4'h0);
        addExec("SBCS c0", immWord(condAl, opSbc, 1, 2, 12, 0, 8'h05), 12, 32'h0, 4'h4);
        addExec("RSCS c0", immWord(condAl, opRsc, 1, 2, 13, 0, 8'h08), 13, 32'h3, 4'h0);
        addEntry("C set", kindFlagWr, addrFlags, 32'h2, 32'h0);
        addExec("RSCS c1", immWord(condAl, opRsc, 1, 2, 13, 0, 8'h05), 13, 32'hffffffff, 4'ha);
        addEntry("C V set", kindFlagWr, addrFlags, 32'h3, 32'h0);
        addExec("ANDS lsl", regWord(condAl, opAnd, 1, 4, 6, 4, shiftLsl, 5), 6, 32'h20406080, 4'h3);
        addExec("EORS lsr", regWord(condAl, opEor, 1, 4, 7, 8, shiftLsr, 5), 7, 32'hf0e2c4a6, 4'hb);
        addExec("ORRS asr", regWord(condAl, opOrr, 1, 2, 8, 4, shiftAsr, 3), 8, 32'hf8000005, 4'hb);
        addExec("BICS ror", regWord(condAl, opBic, 1, 4, 9, 16, shiftRor, 5), 9, 32'ha080e0c0, 4'hb);
        addExec("MOVS ror", regWord(condAl, opMov, 1, 0, 10, 4, shiftRor, 5), 10, 32'h81234567, 4'hb);
        addExec("MVNS", regWord(condAl, opMvn, 1, 0, 11, 0, shiftLsl, 3), 11, 32'h7fffffff, 4'h3);
        // Compares name r6 as Rd and must leave it alone
        addExec("TST", immWord(condAl, opTst, 1, 4, 6, 0, 8'h0f), 6, 32'h20406080, 4'h7);
        addExec("TEQ", regWord(condAl, opTeq, 1, 4, 6, 0, shiftLsl, 5), 6, 32'h20406080, 4'hb);
        addExec("CMP", immWord(condAl, opCmp, 1, 2, 6, 0, 8'h07), 6, 32'h20406080, 4'ha);
        addExec("CMN", immWord(condAl, opCmn, 1, 1, 6, 0, 8'h01), 6, 32'h20406080, 4'h9);
        addExec("ADD no S", immWord(condAl, opAdd, 0, 2, 14, 0, 8'h01), 14, 32'h6, 4'h9);
        addExec("ADDEQS", immWord(condEq, opAdd, 1, 2, 14, 0, 8'h20), 14, 32'h6, 4'h9);
        addExec("ADDNVS", immWord(condNv, opAdd, 1, 2, 14, 0, 8'h20), 14, 32'h6, 4'h9);
        addExec("ADDGTS", immWord(condGt, opAdd, 1, 2, 14, 0, 8'h20), 14, 32'h25, 4'h0);
        addExec("SUBLS", immWord(condLs, opSub, 0, 2, 13, 0, 8'h01), 13, 32'h4, 4'h0);
        addExec("reg shift", regWord(condAl, opAdd, 1, 3, 14, 0, shiftLsl, 3) | 32'h10,
                14, 32'h25, 4'h0);
        // Held word of the last instruction
        addEntry("instr read", kindRegRd, addrInstr, 32'h0,
                 regWord(condAl, opAdd, 1, 3, 14, 0, shiftLsl, 3) | 32'h10);
    endtask

    task automatic busCycle(input logic isWrite, input logic [4:0] address,
            input logic [31:0] data);
        @(negedge Clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = isWrite;
        adr   = address;
        datIn = data;
        @(negedge Clk);
        while (!ack) @(negedge Clk);
        @(negedge Clk);  // Past the edge that takes the ack
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    initial begin
        Clk = 1'b0;
        forever #(clkPeriod / 2) Clk = ~Clk;
    end

    initial begin
        wait (numTests > 0);
        #((numTests * 20 + 10) * clkPeriod);
        $display("ERROR: watchdog expired, the bus stopped answering before the tests ended");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        reset = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        datIn = '0;
        buildTable();
        numTests = names.size();
        repeat (10) @(negedge Clk);
        reset = 1'b0;
        for (int i = 0; i < numTests; i++) begin
            busCheck.loadExpected(names[i], exps[i]);
            busCycle(kinds[i] <= kindInstr, addrs[i], datas[i]);
        end
        repeat (2) @(negedge Clk);
        busCheck.printCounts();
        if (errorCount == 0 && readCount == expectedReads) begin
            $display("** PASS **");
        end else begin
            if (readCount != expectedReads)
                $display("ERROR: only %0d of %0d reads were checked", readCount, expectedReads);
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/cpuPkg.sv
hdl/registerFile.sv
hdl/operandShifter.sv
hdl/aluCore.sv
hdl/statusFlags.sv
hdl/wbSequencer.sv
hdl/dpTop.sv
bench/dpChecker.sv
bench/dpTopTb.sv

// ==== hdl/aluCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluCore (
    input  cpuPkg::instrWord_u               instr,
    input  logic [cpuPkg::dataWidth-1:0]     rnData,
    input  logic [cpuPkg::dataWidth-1:0]     operand2,
    input  logic                             carryIn,
    output logic [cpuPkg::dataWidth-1:0]     result,
    output logic [3:0]                       nzcv,
    output logic                             writesRd,
    output logic                             updatesCV
);
    import cpuPkg::*;

    logic [3:0]           aluOp;
    logic [dataWidth-1:0] minuend;
    logic [dataWidth-1:0] subtrahend;
    logic [dataWidth:0]   sum;
    logic                 useCarry;
    logic                 c;
    logic                 v;

    always_comb begin
        case (instr.immForm.opcode)
            4'b0000, 4'b1000: aluOp = aluAnd;   // AND, TST
            4'b0001, 4'b1001: aluOp = aluXor;   // EOR, TEQ
            4'b0010, 4'b1010: aluOp = aluSub;   // SUB, CMP
            4'b0011:          aluOp = aluRsb;
            4'b0100, 4'b1011: aluOp = aluAdd;   // ADD, CMN
            4'b0101:          aluOp = aluAdc;
            4'b0110:          aluOp = aluSbc;
            4'b0111:          aluOp = aluRsc;
            4'b1100:          aluOp = aluOr;
            4'b1101:          aluOp = aluPassB;
            4'b1110:          aluOp = aluAndNotB;
            default:          aluOp = aluNotB;  // MVN
        endcase
    end

    // Compare group 10xx only sets flags
    assign writesRd = (instr.immForm.opcode[3:2] != 2'b10);

    always_comb begin
        useCarry   = (aluOp == aluAdc) || (aluOp == aluSbc) || (aluOp == aluRsc);
        minuend    = (aluOp == aluRsb || aluOp == aluRsc) ? operand2 : rnData;
        subtrahend = (aluOp == aluRsb || aluOp == aluRsc) ? rnData : operand2;
        sum        = {1'b0, rnData} + {1'b0, operand2} + (useCarry ? carryIn : 1'b0);
        result     = '0;
        c          = carryIn;
        v          = 1'b0;
        updatesCV  = 1'b1;
        case (aluOp)
            aluAdd, aluAdc: begin
                result = sum[dataWidth-1:0];
                c      = sum[dataWidth];
                v      = ~(rnData[31] ^ operand2[31]) & (rnData[31] ^ result[31]);
            end
            aluSub, aluSbc, aluRsb, aluRsc: begin
                result = minuend - subtrahend - (useCarry ? carryIn : 1'b0);
                c      = {1'b0, minuend} < ({1'b0, subtrahend} + (useCarry ? carryIn : 1'b0));
                v      = (minuend[31] ^ subtrahend[31]) & (minuend[31] ^ result[31]);
            end
            aluAnd:     begin result = rnData & operand2;  updatesCV = 1'b0; end
            aluOr:      begin result = rnData | operand2;  updatesCV = 1'b0; end
            aluXor:     begin result = rnData ^ operand2;  updatesCV = 1'b0; end
            aluPassB:   begin result = operand2;           updatesCV = 1'b0; end
            aluAndNotB: begin result = rnData & ~operand2; updatesCV = 1'b0; end
            default:    begin result = ~operand2;          updatesCV = 1'b0; end
        endcase
    end

    assign nzcv = {result[dataWidth-1], result == '0, c, v};

endmodule

`default_nettype wire

// ==== hdl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 4;

    // ALU operation codes
    localparam logic [3:0] aluAdd = 4'b0000, aluAdc = 4'b0001, aluSub = 4'b0010,
                           aluSbc = 4'b0011, aluRsb = 4'b0100, aluRsc = 4'b0101;
    localparam logic [3:0] aluAnd = 4'b0110, aluOr = 4'b0111, aluXor = 4'b1000;
    localparam logic [3:0] aluPassB = 4'b1010, aluNotB = 4'b1011, aluAndNotB = 4'b1100;

    // Condition field in bits 31..28
    localparam logic [3:0] condEq = 4'h0, condNe = 4'h1, condCs = 4'h2, condCc = 4'h3;
    localparam logic [3:0] condMi = 4'h4, condPl = 4'h5, condVs = 4'h6, condVc = 4'h7;
    localparam logic [3:0] condHi = 4'h8, condLs = 4'h9, condGe = 4'ha, condLt = 4'hb;
    localparam logic [3:0] condGt = 4'hc, condLe = 4'hd, condAl = 4'he, condNv = 4'hf;

    localparam logic [1:0] shiftLsl = 2'b00, shiftLsr = 2'b01, shiftAsr = 2'b10,
                           shiftRor = 2'b11;

    // Word addresses above the register window
    localparam logic [4:0] addrInstr = 5'd16;
    localparam logic [4:0] addrFlags = 5'd17;

    typedef struct packed {
        logic [3:0] cond;
        logic [1:0] opClass;     // 00 for data processing
        logic       format;      // 1 selects rotated immediate
        logic [3:0] opcode;
        logic       s;
        logic [3:0] rn;
        logic [3:0] rd;
        logic [3:0] rotate;
        logic [7:0] imm8;
    } immForm_s;

    typedef struct packed {
        logic [3:0] cond;
        logic [1:0] opClass;
        logic       format;
        logic [3:0] opcode;
        logic       s;
        logic [3:0] rn;
        logic [3:0] rd;
        logic [4:0] shiftAmount;
        logic [1:0] shiftType;
        logic       regShiftFlag; // Shift by register is not executed here
        logic [3:0] rm;
    } regForm_s;

    typedef union packed {
        immForm_s immForm;
        regForm_s regForm;
    } instrWord_u;

endpackage

`default_nettype wire

// ==== hdl/dpTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module dpTop (
    input  logic                          Clk,
    input  logic                          reset,
    input  logic                          cyc,
    input  logic                          stb,
    input  logic                          we,
    input  logic [4:0]                    adr,
    input  logic [cpuPkg::dataWidth-1:0]  datIn,
    output logic [cpuPkg::dataWidth-1:0]  datOut,
    output logic                          ack
);
    import cpuPkg::*;

    instrWord_u              instr;
    logic [regAddrWidth-1:0] rdAddrA;
    logic [regAddrWidth-1:0] rdAddrB;
    logic [regAddrWidth-1:0] wrAddr;
    logic [dataWidth-1:0]    rnData;
    logic [dataWidth-1:0]    rmData;
    logic [dataWidth-1:0]    wrData;
    logic [dataWidth-1:0]    operand2;
    logic [dataWidth-1:0]    aluResult;
    logic [3:0]              aluNzcv;
    logic [3:0]              flags;
    logic [3:0]              hostFlags;
    logic                    wrEn;
    logic                    carry;
    logic                    writesRd;
    logic                    updatesCV;
    logic                    condPass;
    logic                    flagsLoad;
    logic                    hostFlagsLoad;

    wbSequencer sequencer (
        .Clk(Clk), .reset(reset),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datIn(datIn),
        .datOut(datOut), .ack(ack),
        .instr(instr),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB), .rnData(rnData),
        .wrAddr(wrAddr), .wrData(wrData), .wrEn(wrEn),
        .aluResult(aluResult), .writesRd(writesRd), .condPass(condPass), .flags(flags),
        .flagsLoad(flagsLoad), .hostFlagsLoad(hostFlagsLoad), .hostFlags(hostFlags)
    );

    registerFile regFile (
        .Clk(Clk), .reset(reset),
        .rdAddrA(rdAddrA), .rdAddrB(rdAddrB),
        .wrAddr(wrAddr), .wrData(wrData), .wrEn(wrEn),
        .rdDataA(rnData), .rdDataB(rmData)
    );

    operandShifter shifter (
        .instr(instr), .rmData(rmData), .operand2(operand2)
    );

    aluCore alu (
        .instr(instr), .rnData(rnData), .operand2(operand2), .carryIn(carry),
        .result(aluResult), .nzcv(aluNzcv), .writesRd(writesRd), .updatesCV(updatesCV)
    );

    statusFlags status (
        .Clk(Clk), .reset(reset),
        .nzcvIn(aluNzcv), .updatesCV(updatesCV), .flagsLoad(flagsLoad),
        .hostFlags(hostFlags), .hostFlagsLoad(hostFlagsLoad),
        .cond(instr.immForm.cond),
        .flags(flags), .carry(carry), .condPass(condPass)
    );

endmodule

`default_nettype wire

// ==== hdl/operandShifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module operandShifter (
    input  cpuPkg::instrWord_u               instr,
    input  logic [cpuPkg::dataWidth-1:0]     rmData,
    output logic [cpuPkg::dataWidth-1:0]     operand2
);
    import cpuPkg::*;

    function automatic logic [dataWidth-1:0] rotateRight(
        input logic [dataWidth-1:0] value,
        input logic [4:0]           amount
    );
        if (amount == 5'd0)
            return value;
        return (value >> amount) | (value << (dataWidth - amount));
    endfunction

    logic [dataWidth-1:0] immValue;
    logic [4:0]           amount;

    assign immValue = {{(dataWidth-8){1'b0}}, instr.immForm.imm8};
    assign amount   = instr.regForm.shiftAmount;

    always_comb begin
        if (instr.immForm.format) begin
            operand2 = rotateRight(immValue, {instr.immForm.rotate, 1'b0});  // Rotate by 2x
        end else begin
            case (instr.regForm.shiftType)
                shiftLsl: operand2 = rmData << amount;
                shiftLsr: operand2 = rmData >> amount;
                shiftAsr: operand2 = $signed(rmData) >>> amount;
                shiftRor: operand2 = rotateRight(rmData, amount);
                default:  operand2 = rmData;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic                             Clk,
    input  logic                             reset,
    input  logic [cpuPkg::regAddrWidth-1:0]  rdAddrA,
    input  logic [cpuPkg::regAddrWidth-1:0]  rdAddrB,
    input  logic [cpuPkg::regAddrWidth-1:0]  wrAddr,
    input  logic [cpuPkg::dataWidth-1:0]     wrData,
    input  logic                             wrEn,
    output logic [cpuPkg::dataWidth-1:0]     rdDataA,
    output logic [cpuPkg::dataWidth-1:0]     rdDataB
);
    import cpuPkg::*;

    logic [dataWidth-1:0] regs [0:14];
    logic [14:0]          wrSel;

    // One-hot write select where index 15 falls off the top
    assign wrSel = wrEn ? (15'(1) << wrAddr) : '0;

    always_ff @(posedge Clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 15; i++)
                regs[i] <= '0;
        end else begin
            for (int i = 0; i < 15; i++)
                if (wrSel[i]) regs[i] <= wrData;
        end
    end

    assign rdDataA = (rdAddrA == 4'd15) ? '0 : regs[rdAddrA];  // r15 reads zero
    assign rdDataB = (rdAddrB == 4'd15) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

// ==== hdl/statusFlags.sv ====
`timescale 1ns/1ps
`default_nettype none

module statusFlags (
    input  logic       Clk,
    input  logic       reset,
    input  logic [3:0] nzcvIn,
    input  logic       updatesCV,
    input  logic       flagsLoad,
    input  logic [3:0] hostFlags,
    input  logic       hostFlagsLoad,
    input  logic [3:0] cond,
    output logic [3:0] flags,
    output logic       carry,
    output logic       condPass
);
    import cpuPkg::*;

    logic n, z, c, v;

    always_ff @(posedge Clk or posedge reset) begin
        if (reset)
            flags <= '0;
        else if (hostFlagsLoad)
            flags <= hostFlags;
        else if (flagsLoad)
            flags <= {nzcvIn[3:2], updatesCV ? nzcvIn[1:0] : flags[1:0]};  // Logic ops keep C, V
    end

    assign {n, z, c, v} = flags;
    assign carry = c;

    always_comb begin
        case (cond)
            condEq:  condPass = z;
            condNe:  condPass = !z;
            condCs:  condPass = c;
            condCc:  condPass = !c;
            condMi:  condPass = n;
            condPl:  condPass = !n;
            condVs:  condPass = v;
            condVc:  condPass = !v;
            condHi:  condPass = c && !z;
            condLs:  condPass = !c || z;
            condGe:  condPass = (n == v);
            condLt:  condPass = (n != v);
            condGt:  condPass = !z && (n == v);
            condLe:  condPass = z || (n != v);
            condAl:  condPass = 1'b1;
            default: condPass = 1'b0;    // NV
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/wbSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module wbSequencer (
    input  logic                             Clk,
    input  logic                             reset,
    input  logic                             cyc,
    input  logic                             stb,
    input  logic                             we,
    input  logic [4:0]                       adr,
    input  logic [cpuPkg::dataWidth-1:0]     datIn,
    output logic [cpuPkg::dataWidth-1:0]     datOut,
    output logic                             ack,
    output cpuPkg::instrWord_u               instr,
    output logic [cpuPkg::regAddrWidth-1:0]  rdAddrA,
    output logic [cpuPkg::regAddrWidth-1:0]  rdAddrB,
    input  logic [cpuPkg::dataWidth-1:0]     rnData,
    output logic [cpuPkg::regAddrWidth-1:0]  wrAddr,
    output logic [cpuPkg::dataWidth-1:0]     wrData,
    output logic                             wrEn,
    input  logic [cpuPkg::dataWidth-1:0]     aluResult,
    input  logic                             writesRd,
    input  logic                             condPass,
    input  logic [3:0]                       flags,
    output logic                             flagsLoad,
    output logic                             hostFlagsLoad,
    output logic [3:0]                       hostFlags
);
    import cpuPkg::*;

    localparam logic [2:0] stIdle      = 3'd0;
    localparam logic [2:0] stAccess    = 3'd1;
    localparam logic [2:0] stOperand   = 3'd2;
    localparam logic [2:0] stExecute   = 3'd3;
    localparam logic [2:0] stWriteback = 3'd4;

    logic [2:0]           state;
    logic [2:0]           nextState;
    logic                 request;
    logic                 instrWrite;
    logic                 busy;
    logic                 hostWrite;
    logic                 execOk;
    logic [dataWidth-1:0] resultHold;

    assign request    = cyc && stb;
    assign instrWrite = we && (adr == addrInstr);

    always_comb begin
        nextState = state;
        case (state)
            stIdle:      if (request) nextState = instrWrite ? stOperand : stAccess;
            stAccess:    nextState = stIdle;
            stOperand:   nextState = stExecute;
            stExecute:   nextState = stWriteback;
            stWriteback: nextState = stIdle;
            default:     nextState = stIdle;
        endcase
    end

    always_ff @(posedge Clk or posedge reset) begin
        if (reset) begin
            state <= stIdle;
            instr <= '0;
        end else begin
            state <= nextState;
            if (state == stIdle && request && instrWrite)
                instr <= datIn;
        end
    end

    always_ff @(posedge Clk) begin
        if (state == stExecute)
            resultHold <= aluResult;   // Rd value for writeback
    end

    assign busy    = (state == stOperand) || (state == stExecute) || (state == stWriteback);
    assign rdAddrA = busy ? instr.immForm.rn : adr[3:0];
    assign rdAddrB = instr.regForm.rm;

    // Shift by register is acknowledged only
    assign execOk = instr.immForm.format || !instr.regForm.regShiftFlag;

    assign ack       = (state == stAccess) || (state == stWriteback);
    assign hostWrite = (state == stAccess) && we;

    assign wrAddr = (state == stWriteback) ? instr.immForm.rd : adr[3:0];
    assign wrData = (state == stWriteback) ? resultHold : datIn;
    assign wrEn   = (hostWrite && !adr[4])
                 || ((state == stWriteback) && execOk && condPass && writesRd);

    assign flagsLoad     = (state == stWriteback) && execOk && condPass && instr.immForm.s;
    assign hostFlagsLoad = hostWrite && (adr == addrFlags);
    assign hostFlags     = datIn[3:0];

    always_comb begin
        if (!adr[4])
            datOut = rnData;
        else if (adr == addrInstr)
            datOut = instr;
        else if (adr == addrFlags)
            datOut = {{(dataWidth-4){1'b0}}, flags};
        else
            datOut = '0;
    end

endmodule

`default_nettype wire
